// ==== source/epu_macros.svh ====
`ifndef EPU_MACROS_SVH
`define EPU_MACROS_SVH

// Datapath widths
`define EPU_DW      32
`define EPU_PCW     30
`define EPU_PSR_DW  10

// MSR address fields
`define EPU_BANK_LSB 9
`define EPU_BANK_W   5
`define EPU_OFF_W    9
`define EPU_IMM_W    15

`define EPU_BANK_PS   5'd0
`define EPU_BANK_IRQC 5'd6

// One-hot offsets, PS bank
`define EPU_OFF_PSR    0
`define EPU_OFF_CPUID  1
`define EPU_OFF_EPSR   2
`define EPU_OFF_EPC    3
`define EPU_OFF_ELSA   4
`define EPU_OFF_COREID 5

// One-hot offsets, IRQC bank
`define EPU_OFF_IMR 0
`define EPU_OFF_IRR 1

// PSR bit positions
`define EPU_PSR_RM   4
`define EPU_PSR_IRE  5
`define EPU_PSR_IMME 6
`define EPU_PSR_DMME 7

// Only RM is set out of reset
`define EPU_PSR_RESET 10'h010

`define EPU_CPUID  32'h0032_0001
`define EPU_COREID 32'h0000_0003

// Exception vectors as byte addresses
`define EPU_VEC_SYSCALL 32'h0000_0100
`define EPU_VEC_EINSN   32'h0000_0200
`define EPU_VEC_EIRQ    32'h0000_0300

`endif

// ==== source/epu_pkg.sv ====
`include "epu_macros.svh"

package epu_pkg;

   typedef logic [`EPU_DW-1:0]     word_t;
   typedef logic [`EPU_PCW-1:0]    pc_t;
   typedef logic [`EPU_PSR_DW-1:0] psr_t;

   // Operations issued to the unit
   typedef enum logic [2:0] {
      OPC_RMSR     = 3'd0,
      OPC_WMSR     = 3'd1,
      OPC_ESYSCALL = 3'd2,
      OPC_ERET     = 3'd3,
      OPC_EINSN    = 3'd4,
      OPC_EIRQ     = 3'd5
   } epu_opc_e;

   // Decoded MSR bank, anything unmapped is BANK_NONE
   typedef enum logic [1:0] {
      BANK_PS   = 2'd0,
      BANK_IRQC = 2'd1,
      BANK_NONE = 2'd2
   } msr_bank_e;

endpackage

// ==== source/epu_decode.sv ====
`timescale 1ns/1ps
`include "epu_macros.svh"

module epu_decode (
   input  logic                       clk,
   input  logic                       arst_n,
   input  logic                       issue_valid,
   input  epu_pkg::pc_t               issue_pc,
   input  epu_pkg::epu_opc_e          issue_opc,
   input  epu_pkg::word_t             issue_operand1,
   input  epu_pkg::word_t             issue_imm,
   input  epu_pkg::word_t             issue_operand2,
   output logic                       d_valid,
   output epu_pkg::pc_t               d_pc,
   output epu_pkg::epu_opc_e          d_opc,
   output epu_pkg::msr_bank_e         d_bank,
   output logic [`EPU_OFF_W-1:0]      d_off,
   output epu_pkg::word_t             d_wdat
);

   epu_pkg::word_t          msr_addr;
   logic [`EPU_BANK_W-1:0]  bank_field;
   epu_pkg::msr_bank_e      bank_dec;

   // Immediate only contributes its low bits
   assign msr_addr = issue_operand1 |
                     {{(`EPU_DW-`EPU_IMM_W){1'b0}}, issue_imm[`EPU_IMM_W-1:0]};
   assign bank_field = msr_addr[`EPU_BANK_LSB +: `EPU_BANK_W];

   always_comb begin
      case (bank_field)
         `EPU_BANK_PS:   bank_dec = epu_pkg::BANK_PS;
         `EPU_BANK_IRQC: bank_dec = epu_pkg::BANK_IRQC;
         default:        bank_dec = epu_pkg::BANK_NONE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         d_valid <= 1'b0;
      end else begin
         d_valid <= issue_valid;
      end
   end

   // Payload only moves with a valid issue
   always_ff @(posedge clk) begin
      if (issue_valid) begin
         d_pc   <= issue_pc;
         d_opc  <= issue_opc;
         d_bank <= bank_dec;
         d_off  <= msr_addr[`EPU_OFF_W-1:0];
         d_wdat <= issue_operand2;
      end
   end

endmodule

// ==== source/epu_execute.sv ====
`timescale 1ns/1ps
`include "epu_macros.svh"

module epu_execute (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   d_valid,
   input  epu_pkg::pc_t           d_pc,
   input  epu_pkg::epu_opc_e      d_opc,
   input  epu_pkg::msr_bank_e     d_bank,
   input  logic [`EPU_OFF_W-1:0]  d_off,
   input  epu_pkg::word_t         d_wdat,
   input  epu_pkg::psr_t          psr,
   input  epu_pkg::psr_t          epsr,
   input  epu_pkg::word_t         epc,
   input  epu_pkg::word_t         elsa,
   input  epu_pkg::word_t         imr,
   input  epu_pkg::word_t         irq_pending,
   output logic                   wb_valid,
   output epu_pkg::pc_t           wb_pc,
   output epu_pkg::word_t         wb_dout,
   output logic                   wb_exc,
   output epu_pkg::pc_t           wb_exc_vec,
   output logic                   c_wmsr,
   output logic                   c_exc_entry,
   output logic                   c_eret,
   output logic                   c_syscall,
   output logic                   c_einsn,
   output epu_pkg::msr_bank_e     c_bank,
   output logic [`EPU_OFF_W-1:0]  c_off,
   output epu_pkg::word_t         c_wdat,
   output epu_pkg::pc_t           c_pc
);

   localparam epu_pkg::word_t VEC_SYSCALL = `EPU_VEC_SYSCALL;
   localparam epu_pkg::word_t VEC_EINSN   = `EPU_VEC_EINSN;
   localparam epu_pkg::word_t VEC_EIRQ    = `EPU_VEC_EIRQ;

   epu_pkg::word_t psr_ext;
   epu_pkg::word_t epsr_ext;
   epu_pkg::word_t rd_ps;
   epu_pkg::word_t rd_irqc;
   epu_pkg::word_t rd_data;
   epu_pkg::pc_t   exc_vec;
   logic           is_entry;
   logic           is_eret;
   logic           is_exc;

   assign psr_ext  = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, psr};
   assign epsr_ext = {{(`EPU_DW-`EPU_PSR_DW){1'b0}}, epsr};

   // AND-OR read mux per bank
   assign rd_ps = ({`EPU_DW{d_off[`EPU_OFF_PSR]}}    & psr_ext)    |
                  ({`EPU_DW{d_off[`EPU_OFF_CPUID]}}  & `EPU_CPUID)  |
                  ({`EPU_DW{d_off[`EPU_OFF_EPSR]}}   & epsr_ext)   |
                  ({`EPU_DW{d_off[`EPU_OFF_EPC]}}    & epc)        |
                  ({`EPU_DW{d_off[`EPU_OFF_ELSA]}}   & elsa)       |
                  ({`EPU_DW{d_off[`EPU_OFF_COREID]}} & `EPU_COREID);

   assign rd_irqc = ({`EPU_DW{d_off[`EPU_OFF_IMR]}} & imr) |
                    ({`EPU_DW{d_off[`EPU_OFF_IRR]}} & irq_pending);

   // Unmapped banks read as zero
   assign rd_data = ({`EPU_DW{d_bank == epu_pkg::BANK_PS}}   & rd_ps) |
                    ({`EPU_DW{d_bank == epu_pkg::BANK_IRQC}} & rd_irqc);

   assign is_entry = (d_opc == epu_pkg::OPC_ESYSCALL) ||
                     (d_opc == epu_pkg::OPC_EINSN) ||
                     (d_opc == epu_pkg::OPC_EIRQ);
   assign is_eret  = (d_opc == epu_pkg::OPC_ERET);
   assign is_exc   = is_entry | is_eret;

   always_comb begin
      case (d_opc)
         epu_pkg::OPC_ESYSCALL: exc_vec = VEC_SYSCALL[`EPU_DW-1:2];
         epu_pkg::OPC_EINSN:    exc_vec = VEC_EINSN[`EPU_DW-1:2];
         epu_pkg::OPC_EIRQ:     exc_vec = VEC_EIRQ[`EPU_DW-1:2];
         // Return target comes from the saved pc
         epu_pkg::OPC_ERET:     exc_vec = epc[`EPU_DW-1:2];
         default:               exc_vec = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid    <= 1'b0;
         wb_exc      <= 1'b0;
         c_wmsr      <= 1'b0;
         c_exc_entry <= 1'b0;
         c_eret      <= 1'b0;
         c_syscall   <= 1'b0;
         c_einsn     <= 1'b0;
      end else begin
         wb_valid    <= d_valid;
         wb_exc      <= d_valid & is_exc;
         c_wmsr      <= d_valid & (d_opc == epu_pkg::OPC_WMSR);
         c_exc_entry <= d_valid & is_entry;
         c_eret      <= d_valid & is_eret;
         c_syscall   <= d_valid & (d_opc == epu_pkg::OPC_ESYSCALL);
         c_einsn     <= d_valid & (d_opc == epu_pkg::OPC_EINSN);
      end
   end

   always_ff @(posedge clk) begin
      if (d_valid) begin
         wb_pc      <= d_pc;
         wb_dout    <= is_exc ? '0 : rd_data;
         wb_exc_vec <= exc_vec;
         c_bank     <= d_bank;
         c_off      <= d_off;
         c_wdat     <= d_wdat;
         c_pc       <= d_pc;
      end
   end

endmodule

// ==== source/epu_result.sv ====
`timescale 1ns/1ps
`include "epu_macros.svh"

module epu_result (
   input  logic                   clk,
   input  logic                   arst_n,
   input  logic                   c_wmsr,
   input  logic                   c_exc_entry,
   input  logic                   c_eret,
   input  logic                   c_syscall,
   input  logic                   c_einsn,
   input  epu_pkg::msr_bank_e     c_bank,
   input  logic [`EPU_OFF_W-1:0]  c_off,
   input  epu_pkg::word_t         c_wdat,
   input  epu_pkg::pc_t           c_pc,
   output epu_pkg::psr_t          psr,
   output epu_pkg::psr_t          epsr,
   output epu_pkg::word_t         epc,
   output epu_pkg::word_t         elsa,
   output epu_pkg::word_t         imr
);

   epu_pkg::pc_t   link_pc;
   epu_pkg::word_t epc_entry;
   epu_pkg::word_t pc_byte;
   logic           wr_ps;
   logic           wr_irqc;

   assign link_pc = c_pc + 1'b1;
   assign pc_byte = {c_pc, 2'b00};

   // Syscall resumes after itself, other exceptions retry the faulting insn
   assign epc_entry = c_syscall ? {link_pc, 2'b00} : pc_byte;

   assign wr_ps   = c_wmsr & (c_bank == epu_pkg::BANK_PS);
   assign wr_irqc = c_wmsr & (c_bank == epu_pkg::BANK_IRQC);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         psr  <= `EPU_PSR_RESET;
         epsr <= '0;
         epc  <= '0;
         elsa <= '0;
         imr  <= '0;
      end else if (c_exc_entry) begin
         epsr              <= psr;
         psr[`EPU_PSR_RM]  <= 1'b1;
         psr[`EPU_PSR_IRE] <= 1'b0;
         epc               <= epc_entry;
         if (c_einsn) begin
            elsa <= pc_byte;
         end
      end else if (c_eret) begin
         // Restore mode and enables saved at entry
         psr[`EPU_PSR_RM]   <= epsr[`EPU_PSR_RM];
         psr[`EPU_PSR_IRE]  <= epsr[`EPU_PSR_IRE];
         psr[`EPU_PSR_IMME] <= epsr[`EPU_PSR_IMME];
         psr[`EPU_PSR_DMME] <= epsr[`EPU_PSR_DMME];
      end else begin
         // Offsets are one-hot, a multi-bit offset hits several registers
         if (wr_ps && c_off[`EPU_OFF_PSR]) begin
            psr <= c_wdat[`EPU_PSR_DW-1:0];
         end
         if (wr_ps && c_off[`EPU_OFF_EPSR]) begin
            epsr <= c_wdat[`EPU_PSR_DW-1:0];
         end
         if (wr_ps && c_off[`EPU_OFF_EPC]) begin
            epc <= c_wdat;
         end
         if (wr_ps && c_off[`EPU_OFF_ELSA]) begin
            elsa <= c_wdat;
         end
         // IRR is read-only
         if (wr_irqc && c_off[`EPU_OFF_IMR]) begin
            imr <= c_wdat;
         end
      end
   end

endmodule

// ==== source/epu_top.sv ====
`timescale 1ns/1ps
`include "epu_macros.svh"

module epu_top (
   input  logic                clk,
   input  logic                arst_n,
   input  logic                issue_valid,
   input  epu_pkg::pc_t        issue_pc,
   input  epu_pkg::epu_opc_e   issue_opc,
   input  epu_pkg::word_t      issue_operand1,
   input  epu_pkg::word_t      issue_operand2,
   input  epu_pkg::word_t      issue_imm,
   input  epu_pkg::word_t      irq_pending,
   output logic                wb_valid,
   output epu_pkg::pc_t        wb_pc,
   output epu_pkg::word_t      wb_dout,
   output logic                wb_exc,
   output epu_pkg::pc_t        wb_exc_vec,
   output epu_pkg::psr_t       psr
);

   // Decode to execute
   logic                  d_valid;
   epu_pkg::pc_t          d_pc;
   epu_pkg::epu_opc_e     d_opc;
   epu_pkg::msr_bank_e    d_bank;
   logic [`EPU_OFF_W-1:0] d_off;
   epu_pkg::word_t        d_wdat;

   // Execute to result
   logic                  c_wmsr;
   logic                  c_exc_entry;
   logic                  c_eret;
   logic                  c_syscall;
   logic                  c_einsn;
   epu_pkg::msr_bank_e    c_bank;
   logic [`EPU_OFF_W-1:0] c_off;
   epu_pkg::word_t        c_wdat;
   epu_pkg::pc_t          c_pc;

   // Committed MSR state
   epu_pkg::psr_t         epsr;
   epu_pkg::word_t        epc;
   epu_pkg::word_t        elsa;
   epu_pkg::word_t        imr;

   epu_decode u_decode (
      .clk            (clk),
      .arst_n         (arst_n),
      .issue_valid    (issue_valid),
      .issue_pc       (issue_pc),
      .issue_opc      (issue_opc),
      .issue_operand1 (issue_operand1),
      .issue_imm      (issue_imm),
      .issue_operand2 (issue_operand2),
      .d_valid        (d_valid),
      .d_pc           (d_pc),
      .d_opc          (d_opc),
      .d_bank         (d_bank),
      .d_off          (d_off),
      .d_wdat         (d_wdat)
   );

   epu_execute u_execute (
      .clk         (clk),
      .arst_n      (arst_n),
      .d_valid     (d_valid),
      .d_pc        (d_pc),
      .d_opc       (d_opc),
      .d_bank      (d_bank),
      .d_off       (d_off),
      .d_wdat      (d_wdat),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc),
      .elsa        (elsa),
      .imr         (imr),
      .irq_pending (irq_pending),
      .wb_valid    (wb_valid),
      .wb_pc       (wb_pc),
      .wb_dout     (wb_dout),
      .wb_exc      (wb_exc),
      .wb_exc_vec  (wb_exc_vec),
      .c_wmsr      (c_wmsr),
      .c_exc_entry (c_exc_entry),
      .c_eret      (c_eret),
      .c_syscall   (c_syscall),
      .c_einsn     (c_einsn),
      .c_bank      (c_bank),
      .c_off       (c_off),
      .c_wdat      (c_wdat),
      .c_pc        (c_pc)
   );

   epu_result u_result (
      .clk         (clk),
      .arst_n      (arst_n),
      .c_wmsr      (c_wmsr),
      .c_exc_entry (c_exc_entry),
      .c_eret      (c_eret),
      .c_syscall   (c_syscall),
      .c_einsn     (c_einsn),
      .c_bank      (c_bank),
      .c_off       (c_off),
      .c_wdat      (c_wdat),
      .c_pc        (c_pc),
      .psr         (psr),
      .epsr        (epsr),
      .epc         (epc),
      .elsa        (elsa),
      .imr         (imr)
   );

endmodule

// ==== bench/epu_model.svh ====
`ifndef EPU_MODEL_SVH
`define EPU_MODEL_SVH

// Model copies of the MSRs, updated in issue order
epu_pkg::psr_t  m_psr;
epu_pkg::psr_t  m_epsr;
epu_pkg::word_t m_epc;
epu_pkg::word_t m_elsa;
epu_pkg::word_t m_imr;

task automatic model_reset();
   m_psr  = `EPU_PSR_RESET;
   m_epsr = '0;
   m_epc  = '0;
   m_elsa = '0;
   m_imr  = '0;
endtask

// Value an MSR read of this address returns
function automatic epu_pkg::word_t model_read(input epu_pkg::word_t addr,
                                              input epu_pkg::word_t irq);
   logic [`EPU_BANK_W-1:0] bank;
   logic [`EPU_OFF_W-1:0]  off;
   epu_pkg::word_t         val;
   bank = addr[`EPU_BANK_LSB +: `EPU_BANK_W];
   off  = addr[`EPU_OFF_W-1:0];
   val  = '0;
   if (bank == `EPU_BANK_PS) begin
      if (off[`EPU_OFF_PSR])    val |= epu_pkg::word_t'(m_psr);
      if (off[`EPU_OFF_CPUID])  val |= `EPU_CPUID;
      if (off[`EPU_OFF_EPSR])   val |= epu_pkg::word_t'(m_epsr);
      if (off[`EPU_OFF_EPC])    val |= m_epc;
      if (off[`EPU_OFF_ELSA])   val |= m_elsa;
      if (off[`EPU_OFF_COREID]) val |= `EPU_COREID;
   end else if (bank == `EPU_BANK_IRQC) begin
      if (off[`EPU_OFF_IMR]) val |= m_imr;
      if (off[`EPU_OFF_IRR]) val |= irq;
   end
   return val;
endfunction

// Expected writeback for one instruction, then its commit on the model
function automatic void epu_expect(input epu_pkg::epu_opc_e opc, input epu_pkg::pc_t pc,
                                   input epu_pkg::word_t op1, input epu_pkg::word_t op2,
                                   input epu_pkg::word_t imm, input epu_pkg::word_t irq,
                                   output epu_pkg::word_t dout, output logic exc,
                                   output epu_pkg::pc_t vec);
   epu_pkg::word_t         addr;
   epu_pkg::word_t         vec_byte;
   epu_pkg::pc_t           link;
   logic [`EPU_BANK_W-1:0] bank;
   logic [`EPU_OFF_W-1:0]  off;
   addr     = op1 | (imm & ((32'd1 << `EPU_IMM_W) - 32'd1));
   bank     = addr[`EPU_BANK_LSB +: `EPU_BANK_W];
   off      = addr[`EPU_OFF_W-1:0];
   link     = pc + 1'b1;
   dout     = '0;
   exc      = 1'b1;
   vec_byte = '0;
   case (opc)
      epu_pkg::OPC_RMSR: begin
         exc  = 1'b0;
         dout = model_read(addr, irq);
      end
      epu_pkg::OPC_WMSR: begin
         exc = 1'b0;
         if (bank == `EPU_BANK_PS) begin
            if (off[`EPU_OFF_PSR])  m_psr  = op2[`EPU_PSR_DW-1:0];
            if (off[`EPU_OFF_EPSR]) m_epsr = op2[`EPU_PSR_DW-1:0];
            if (off[`EPU_OFF_EPC])  m_epc  = op2;
            if (off[`EPU_OFF_ELSA]) m_elsa = op2;
         end else if (bank == `EPU_BANK_IRQC && off[`EPU_OFF_IMR]) begin
            m_imr = op2;
         end
      end
      epu_pkg::OPC_ERET: begin
         vec_byte = m_epc;
         m_psr[`EPU_PSR_RM]   = m_epsr[`EPU_PSR_RM];
         m_psr[`EPU_PSR_IRE]  = m_epsr[`EPU_PSR_IRE];
         m_psr[`EPU_PSR_IMME] = m_epsr[`EPU_PSR_IMME];
         m_psr[`EPU_PSR_DMME] = m_epsr[`EPU_PSR_DMME];
      end
      epu_pkg::OPC_ESYSCALL, epu_pkg::OPC_EINSN, epu_pkg::OPC_EIRQ: begin
         vec_byte = (opc == epu_pkg::OPC_ESYSCALL) ? `EPU_VEC_SYSCALL :
                    (opc == epu_pkg::OPC_EINSN)    ? `EPU_VEC_EINSN : `EPU_VEC_EIRQ;
         m_epsr = m_psr;
         m_psr[`EPU_PSR_RM]  = 1'b1;
         m_psr[`EPU_PSR_IRE] = 1'b0;
         // Syscall returns past itself
         m_epc = (opc == epu_pkg::OPC_ESYSCALL) ? {link, 2'b00} : {pc, 2'b00};
         if (opc == epu_pkg::OPC_EINSN) m_elsa = {pc, 2'b00};
      end
      default: exc = 1'b0;
   endcase
   vec = vec_byte[`EPU_DW-1:2];
endfunction

`endif

// ==== bench/epu_tb.sv ====
`timescale 1ns/1ps
`include "epu_macros.svh"

module epu_tb;

   localparam int CLK_HALF  = 50;
   localparam int DRV_DLY   = 1;
   localparam int DRAIN_MAX = 20;

   logic                clk;
   logic                arst_n;
   logic                issue_valid;
   epu_pkg::pc_t        issue_pc;
   epu_pkg::epu_opc_e   issue_opc;
   epu_pkg::word_t      issue_operand1;
   epu_pkg::word_t      issue_operand2;
   epu_pkg::word_t      issue_imm;
   epu_pkg::word_t      irq_pending;
   logic                wb_valid;
   epu_pkg::pc_t        wb_pc;
   epu_pkg::word_t      wb_dout;
   logic                wb_exc;
   epu_pkg::pc_t        wb_exc_vec;
   epu_pkg::psr_t       psr;

   int           errors = 0;
   int           cycle = 0;
   int           seed;
   epu_pkg::pc_t next_pc;

   // Expected results in issue order
   string          q_name[$];
   epu_pkg::word_t q_dout[$];
   logic           q_exc[$];
   logic           q_chk[$];
   epu_pkg::pc_t   q_vec[$];
   epu_pkg::pc_t   q_pc[$];
   int             q_cycle[$];

   `include "epu_model.svh"

   epu_top u_dut (
      .clk            (clk),
      .arst_n         (arst_n),
      .issue_valid    (issue_valid),
      .issue_pc       (issue_pc),
      .issue_opc      (issue_opc),
      .issue_operand1 (issue_operand1),
      .issue_operand2 (issue_operand2),
      .issue_imm      (issue_imm),
      .irq_pending    (irq_pending),
      .wb_valid       (wb_valid),
      .wb_pc          (wb_pc),
      .wb_dout        (wb_dout),
      .wb_exc         (wb_exc),
      .wb_exc_vec     (wb_exc_vec),
      .psr            (psr)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #CLK_HALF clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycle <= cycle + 1;
   end

   // Results are sampled mid-cycle
   always @(negedge clk) begin : compare
      string          name;
      epu_pkg::word_t exp_dout;
      logic           exp_exc;
      logic           chk_dout;
      epu_pkg::pc_t   exp_vec;
      epu_pkg::pc_t   exp_pc;
      int             exp_cycle;
      if (!arst_n) begin
         assert (wb_valid === 1'b0) else begin
            $display("Error: wb_valid high during reset at %0t", $time);
            errors++;
         end
      end else if (wb_valid === 1'b1) begin
         assert (q_name.size() != 0) else begin
            $display("Error: result for pc %h arrived with nothing outstanding", wb_pc);
            errors++;
         end
         if (q_name.size() != 0) begin
            name      = q_name.pop_front();
            exp_dout  = q_dout.pop_front();
            exp_exc   = q_exc.pop_front();
            chk_dout  = q_chk.pop_front();
            exp_vec   = q_vec.pop_front();
            exp_pc    = q_pc.pop_front();
            exp_cycle = q_cycle.pop_front();
            assert (cycle == exp_cycle) else begin
               $display("Mismatch %s: cycle expected %0d actual %0d", name, exp_cycle, cycle);
               errors++;
            end
            assert (wb_pc === exp_pc) else begin
               $display("Mismatch %s: wb_pc expected %h actual %h", name, exp_pc, wb_pc);
               errors++;
            end
            assert (wb_exc === exp_exc) else begin
               $display("Mismatch %s: wb_exc expected %b actual %b", name, exp_exc, wb_exc);
               errors++;
            end
            if (chk_dout) begin
               assert (wb_dout === exp_dout) else begin
                  $display("Mismatch %s: wb_dout expected %h actual %h",
                           name, exp_dout, wb_dout);
                  errors++;
               end
            end
            if (exp_exc) begin
               assert (wb_exc_vec === exp_vec) else begin
                  $display("Mismatch %s: wb_exc_vec expected %h actual %h",
                           name, exp_vec, wb_exc_vec);
                  errors++;
               end
            end
         end
      end
   end

   task automatic check_psr(input string name);
      assert (psr === m_psr) else begin
         $display("Mismatch %s: psr expected %h actual %h", name, m_psr, psr);
         errors++;
      end
   endtask

   // Queue the expectation and present one instruction with valid left high
   task automatic drive(input string name, input epu_pkg::epu_opc_e opc,
                        input epu_pkg::pc_t pc, input epu_pkg::word_t op1,
                        input epu_pkg::word_t op2, input epu_pkg::word_t imm);
      epu_pkg::word_t dout;
      logic           exc;
      epu_pkg::pc_t   vec;
      epu_expect(opc, pc, op1, op2, imm, irq_pending, dout, exc, vec);
      q_name.push_back(name);
      q_dout.push_back(dout);
      q_exc.push_back(exc);
      // WMSR writeback data has no defined value
      q_chk.push_back(opc != epu_pkg::OPC_WMSR);
      q_vec.push_back(vec);
      q_pc.push_back(pc);
      q_cycle.push_back(cycle + 2);
      issue_valid    = 1'b1;
      issue_opc      = opc;
      issue_pc       = pc;
      issue_operand1 = op1;
      issue_operand2 = op2;
      issue_imm      = imm;
   endtask

   // One instruction then two idle cycles so that it has committed on return
   task automatic issue_spaced(input string name, input epu_pkg::epu_opc_e opc,
                               input epu_pkg::pc_t pc, input epu_pkg::word_t op1,
                               input epu_pkg::word_t op2, input epu_pkg::word_t imm);
      drive(name, opc, pc, op1, op2, imm);
      @(posedge clk);
      #DRV_DLY;
      issue_valid = 1'b0;
      @(posedge clk);
      @(posedge clk);
      #DRV_DLY;
      check_psr(name);
   endtask

   task automatic read_msr(input string name, input epu_pkg::word_t op1,
                           input epu_pkg::word_t imm);
      issue_spaced(name, epu_pkg::OPC_RMSR, next_pc, op1, 32'h0, imm);
      next_pc++;
   endtask

   task automatic write_msr(input string name, input epu_pkg::word_t op1,
                            input epu_pkg::word_t data, input epu_pkg::word_t imm);
      issue_spaced(name, epu_pkg::OPC_WMSR, next_pc, op1, data, imm);
      next_pc++;
   endtask

   task automatic random_mix(input int count);
      epu_pkg::word_t         r;
      epu_pkg::word_t         split;
      epu_pkg::word_t         addr;
      epu_pkg::word_t         pc_r;
      epu_pkg::word_t         data;
      logic [`EPU_BANK_W-1:0] bank;
      for (int i = 0; i < count; i++) begin
         r = $random(seed);
         // Mostly mapped banks with one in four random
         case (r[9:8])
            2'd2:    bank = `EPU_BANK_IRQC;
            2'd3:    bank = r[18:14];
            default: bank = `EPU_BANK_PS;
         endcase
         addr        = {r[31:14], bank, 9'd1 << (r[13:10] % 4'd9)};
         split       = $random(seed);
         irq_pending = $random(seed);
         pc_r        = $random(seed);
         data        = $random(seed);
         issue_spaced("random_mix", epu_pkg::epu_opc_e'(r[2:0] % 3'd6),
                      pc_r[`EPU_PCW-1:0], addr & ~{17'h0, split[14:0]}, data,
                      {split[31:15], addr[14:0] & split[14:0]});
      end
   endtask

   // Back-to-back RMSRs that leave the state unchanged
   task automatic burst_reads();
      epu_pkg::word_t addrs[8];
      addrs = '{32'h002, 32'h020, 32'h008, 32'h010, 32'h004, 32'hC01, 32'hC02, 32'h601};
      for (int i = 0; i < 8; i++) begin
         drive("burst_reads", epu_pkg::OPC_RMSR, next_pc, addrs[i], 32'h0, 32'h0);
         next_pc++;
         @(posedge clk);
         #DRV_DLY;
      end
      issue_valid = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (q_name.size() != 0 && n < DRAIN_MAX) begin
         @(posedge clk);
         n++;
      end
      assert (q_name.size() == 0) else begin
         $display("Error: timeout with %0d results still outstanding", q_name.size());
         errors++;
      end
   endtask

   initial begin
      seed           = 32'h4bdd55bf;
      next_pc        = 30'h0000_0040;
      arst_n         = 1'b0;
      // Traffic during reset must not reach writeback
      issue_valid    = 1'b1;
      issue_pc       = '0;
      issue_opc      = epu_pkg::OPC_RMSR;
      issue_operand1 = '0;
      issue_operand2 = '0;
      issue_imm      = '0;
      irq_pending    = '0;
      model_reset();
      repeat (8) @(posedge clk);
      #DRV_DLY;
      issue_valid = 1'b0;
      arst_n      = 1'b1;
      check_psr("reset_psr");
      read_msr("reset_cpuid", 32'h002, 32'h0);
      read_msr("reset_coreid", 32'h020, 32'h0);
      read_msr("reset_psr_read", 32'h001, 32'h0);

      write_msr("wr_epsr", 32'h004, 32'h0000_F2A5, 32'h0);
      read_msr("rd_epsr", 32'h004, 32'h0);
      // Address bits come only from the immediate here
      write_msr("wr_epc_imm", 32'h0, 32'hDEAD_BEEC, 32'hFFFF_8008);
      read_msr("rd_epc", 32'h008, 32'h0);
      read_msr("addr_high_bits", 32'hFFFF_C008, 32'h0);
      write_msr("wr_elsa", 32'h010, 32'h1234_5678, 32'h0);
      read_msr("rd_elsa", 32'h0, 32'h010);
      write_msr("wr_imr", 32'h0000_0C00, 32'hA5A5_0F0F, 32'h1);
      read_msr("rd_imr", 32'hC01, 32'h0);
      irq_pending = 32'h8001_0040;
      read_msr("rd_irr", 32'hC00, 32'h2);
      read_msr("rd_unmapped_bank", 32'h601, 32'h0);
      read_msr("rd_unmapped_off", 32'h080, 32'h0);
      write_msr("wr_unmapped", 32'h608, 32'h5555_AAAA, 32'h0);
      read_msr("rd_epc_kept", 32'h008, 32'h0);
      write_msr("wr_cpuid", 32'h002, 32'hFFFF_FFFF, 32'h0);
      read_msr("rd_cpuid_kept", 32'h002, 32'h0);

      write_msr("wr_psr", 32'h001, 32'h0000_00E0, 32'h0);
      issue_spaced("syscall", epu_pkg::OPC_ESYSCALL, 30'h0000_0100, '0, '0, '0);
      read_msr("syscall_epc", 32'h008, 32'h0);
      read_msr("syscall_epsr", 32'h004, 32'h0);
      issue_spaced("einsn", epu_pkg::OPC_EINSN, 30'h0000_2345, '0, '0, '0);
      read_msr("einsn_elsa", 32'h010, 32'h0);
      read_msr("einsn_epc", 32'h008, 32'h0);
      read_msr("einsn_epsr", 32'h004, 32'h0);
      issue_spaced("eirq", epu_pkg::OPC_EIRQ, 30'h3FFF_FFFF, '0, '0, '0);
      read_msr("eirq_epc", 32'h008, 32'h0);

      write_msr("eret_epsr", 32'h004, 32'h0000_03A0, 32'h0);
      write_msr("eret_epc", 32'h008, 32'h0000_4560, 32'h0);
      issue_spaced("eret", epu_pkg::OPC_ERET, 30'h0000_0500, '0, '0, '0);
      write_msr("eret2_epsr", 32'h004, 32'h0000_005F, 32'h0);
      issue_spaced("eret2", epu_pkg::OPC_ERET, 30'h0000_0510, '0, '0, '0);
      read_msr("eret_psr_read", 32'h001, 32'h0);

      random_mix(200);
      burst_reads();
      wait_drain();

      $display("Summary: %0d errors", errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

// ==== epu.f ====
+incdir+source
+incdir+bench
source/epu_pkg.sv
source/epu_decode.sv
source/epu_execute.sv
source/epu_result.sv
source/epu_top.sv
bench/epu_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module epu_tb -f epu.f || exit 1
./obj_dir/Vepu_tb | tee /dev/stderr | grep "All tests passed" > /dev/null &&
   echo "Simulation passed" ||
   { echo "Simulation failed"; exit 1; }
